//--- Makefile
SRCS := $(filter %.sv,$(shell cat cpu.f))

obj_dir/Vcpu_tb: cpu.f cpu_macros.svh $(SRCS)
	verilator --binary --assert --top-module cpu_tb -f cpu.f

run: obj_dir/Vcpu_tb
	./obj_dir/Vcpu_tb | awk '{ print } /^Verification passed$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir

.PHONY: run clean

//--- addr_gen.sv
`include "cpu_macros.svh"

module addr_gen import cpu_pkg::*; (
	input  ctrl_t                ctrl_i,
	input  logic [`CPU_XLEN-1:0] ex_pc_i,
	input  logic [`CPU_XLEN-1:0] imm_i,
	input  logic                 alu_zero_i,
	input  logic [`CPU_XLEN-1:0] fetch_pc_i,
	output logic                 redirect_o,
	output logic [`CPU_XLEN-1:0] npc_o,
	output logic [`CPU_XLEN-1:0] link_o
);
	logic take_branch;
	logic [`CPU_XLEN-1:0] target;
	logic [`CPU_XLEN-1:0] seq_pc;

	// alu ran sub, so zero means equal
	assign take_branch = ctrl_i.is_branch && (ctrl_i.branch_ne ? !alu_zero_i : alu_zero_i);

	assign target = ex_pc_i + imm_i;
	assign seq_pc = fetch_pc_i + `CPU_XLEN'(4);

	assign redirect_o = take_branch || ctrl_i.is_jump;
	assign npc_o = redirect_o ? target : seq_pc;

	assign link_o = ex_pc_i + `CPU_XLEN'(4); // jal rd value

endmodule

//--- alu.sv
`include "cpu_macros.svh"

module alu import cpu_pkg::*; (
	input  alu_op_e              op_i,
	input  logic [`CPU_XLEN-1:0] a_i,
	input  logic [`CPU_XLEN-1:0] b_i,
	output logic [`CPU_XLEN-1:0] result_o,
	output logic                 zero_o
);
	logic [4:0] shamt;
	logic less;

	assign shamt = b_i[4:0];
	assign less = $signed(a_i) < $signed(b_i);

	always_comb begin
		case (op_i)
			alu_add:
				result_o = a_i + b_i;
			alu_sub:
				result_o = a_i - b_i;
			alu_and:
				result_o = a_i & b_i;
			alu_or:
				result_o = a_i | b_i;
			alu_xor:
				result_o = a_i ^ b_i;
			alu_slt:
				result_o = {{(`CPU_XLEN-1){1'b0}}, less};
			alu_sll:
				result_o = a_i << shamt;
			alu_srl:
				result_o = a_i >> shamt; // logical only
			alu_pass_b:
				result_o = b_i;
			default:
				result_o = '0;
		endcase
	end

	assign zero_o = (result_o == '0);

endmodule

//--- cpu.f
+incdir+.
cpu_pkg.sv
decoder.sv
gpr.sv
alu.sv
addr_gen.sv
hazard.sv
cpu.sv
cpu_assert.sv
cpu_tb.sv

//--- cpu.sv
`include "cpu_macros.svh"

module cpu import cpu_pkg::*; (
	input  logic                 clock_i,
	input  logic                 rst_i,
	input  logic [31:0]          inst_i,
	input  logic [`CPU_XLEN-1:0] load_data_i,
	output logic [`CPU_XLEN-1:0] pc_o,
	output logic [`CPU_XLEN-1:0] address_o,
	output logic [`CPU_XLEN-1:0] store_data_o,
	output logic                 mem_load_o,
	output logic                 mem_store_o
);
	logic [`CPU_XLEN-1:0] pc;
	if_id_t if_id;
	id_ex_t id_ex;
	ex_mem_t ex_mem;
	mem_wb_t mem_wb;

	ctrl_t id_ctrl;
	logic [4:0] id_rs1, id_rs2, id_rd;
	logic [`CPU_XLEN-1:0] id_imm, id_rdata1, id_rdata2;
	logic stall, flush;

	logic [`CPU_XLEN-1:0] fwd_a, fwd_b, alu_b, alu_result;
	logic [`CPU_XLEN-1:0] ex_result, npc, link;
	logic alu_zero, redirect;

	logic [`CPU_XLEN-1:0] mem_value;

	// youngest matching writer wins
	function automatic logic [`CPU_XLEN-1:0] forward(input logic [4:0] idx,
			input logic [`CPU_XLEN-1:0] rval);
		if (ex_mem.reg_write && ex_mem.rd != 5'd0 && ex_mem.rd == idx)
			return mem_value;
		if (mem_wb.reg_write && mem_wb.rd != 5'd0 && mem_wb.rd == idx)
			return mem_wb.value;
		return rval;
	endfunction

	always_ff @(posedge clock_i) begin
		if (rst_i)
			pc <= `CPU_RESET_PC;
		else if (!stall)
			pc <= npc;
	end

	assign pc_o = pc;

	always_ff @(posedge clock_i) begin
		if (rst_i || flush) begin
			if_id <= '0;
		end else if (!stall) begin
			if_id.pc <= pc;
			if_id.inst <= inst_i;
		end
	end

	decoder decoder_i (
		.inst_i(if_id.inst),
		.ctrl_o(id_ctrl),
		.rs1_o(id_rs1),
		.rs2_o(id_rs2),
		.rd_o(id_rd),
		.imm_o(id_imm)
	);

	gpr gpr_i (
		.clock_i(clock_i),
		.rst_i(rst_i),
		.we_i(mem_wb.reg_write),
		.waddr_i(mem_wb.rd),
		.wdata_i(mem_wb.value),
		.raddr1_i(id_rs1),
		.raddr2_i(id_rs2),
		.rdata1_o(id_rdata1),
		.rdata2_o(id_rdata2)
	);

	hazard hazard_i (
		.rs1_i(id_rs1),
		.rs2_i(id_rs2),
		.ex_rd_i(id_ex.rd),
		.ex_is_load_i(id_ex.ctrl.is_load),
		.redirect_i(redirect),
		.stall_o(stall),
		.flush_o(flush)
	);

	always_ff @(posedge clock_i) begin
		if (rst_i || flush || stall)
			id_ex <= '0; // bubble
		else
			id_ex <= '{pc: if_id.pc, rs1_val: id_rdata1, rs2_val: id_rdata2, imm: id_imm,
				rs1: id_rs1, rs2: id_rs2, rd: id_rd, ctrl: id_ctrl};
	end

	always_comb begin
		fwd_a = forward(id_ex.rs1, id_ex.rs1_val);
		fwd_b = forward(id_ex.rs2, id_ex.rs2_val);
	end

	assign alu_b = id_ex.ctrl.use_imm ? id_ex.imm : fwd_b;

	alu alu_i (
		.op_i(id_ex.ctrl.alu_op),
		.a_i(fwd_a),
		.b_i(alu_b),
		.result_o(alu_result),
		.zero_o(alu_zero)
	);

	addr_gen addr_gen_i (
		.ctrl_i(id_ex.ctrl),
		.ex_pc_i(id_ex.pc),
		.imm_i(id_ex.imm),
		.alu_zero_i(alu_zero),
		.fetch_pc_i(pc),
		.redirect_o(redirect),
		.npc_o(npc),
		.link_o(link)
	);

	assign ex_result = id_ex.ctrl.is_jump ? link : alu_result;

	always_ff @(posedge clock_i) begin
		if (rst_i)
			ex_mem <= '0;
		else
			ex_mem <= '{result: ex_result, store_data: fwd_b, rd: id_ex.rd,
				reg_write: id_ex.ctrl.reg_write, is_load: id_ex.ctrl.is_load,
				is_store: id_ex.ctrl.is_store};
	end

	assign address_o = ex_mem.result;
	assign store_data_o = ex_mem.store_data;
	assign mem_load_o = ex_mem.is_load;
	assign mem_store_o = ex_mem.is_store;

	// load data arrives in the same cycle
	assign mem_value = ex_mem.is_load ? load_data_i : ex_mem.result;

	always_ff @(posedge clock_i) begin
		if (rst_i)
			mem_wb <= '0;
		else
			mem_wb <= '{value: mem_value, rd: ex_mem.rd, reg_write: ex_mem.reg_write};
	end

endmodule

//--- cpu_assert.sv
`include "cpu_macros.svh"

module cpu_assert (
	input logic                 clock_i,
	input logic                 rst_i,
	input logic [`CPU_XLEN-1:0] pc_i,
	input logic                 mem_load_i,
	input logic                 mem_store_i
);
	// one data access per cycle
	one_access: assert property (@(posedge clock_i) !(mem_load_i && mem_store_i))
		else $error("load and store requested in the same cycle");

	reset_state: assert property (@(posedge clock_i)
		rst_i |=> (pc_i == `CPU_RESET_PC && !mem_store_i))
		else $error("pc not at reset vector or store active during reset");

	pc_aligned: assert property (@(posedge clock_i) disable iff (rst_i) pc_i[1:0] == 2'b00)
		else $error("pc is not word aligned");

endmodule

bind cpu cpu_assert cpu_assert_i (
	.clock_i(clock_i),
	.rst_i(rst_i),
	.pc_i(pc_o),
	.mem_load_i(mem_load_o),
	.mem_store_i(mem_store_o)
);

//--- cpu_macros.svh
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// data and address width
`define CPU_XLEN 32

// architectural registers, x0 included
`define CPU_NREG 32

// first fetch address after reset
`define CPU_RESET_PC 32'h0000_0000

`endif

//--- cpu_pkg.sv
`include "cpu_macros.svh"

package cpu_pkg;

	// RV32I major opcodes handled by the core
	typedef enum logic [6:0] {
		opc_op     = 7'b0110011,
		opc_op_imm = 7'b0010011,
		opc_lui    = 7'b0110111,
		opc_load   = 7'b0000011,
		opc_store  = 7'b0100011,
		opc_branch = 7'b1100011,
		opc_jal    = 7'b1101111
	} opcode_e;

	typedef enum logic [3:0] {
		alu_add    = 4'd0,
		alu_sub    = 4'd1,
		alu_and    = 4'd2,
		alu_or     = 4'd3,
		alu_xor    = 4'd4,
		alu_slt    = 4'd5,
		alu_sll    = 4'd6,
		alu_srl    = 4'd7,
		alu_pass_b = 4'd8 // lui
	} alu_op_e;

	// all zero means bubble
	typedef struct packed {
		alu_op_e alu_op;
		logic    use_imm;
		logic    reg_write;
		logic    is_load;
		logic    is_store;
		logic    is_branch;
		logic    branch_ne;
		logic    is_jump;
	} ctrl_t;

	typedef struct packed {
		logic [`CPU_XLEN-1:0] pc;
		logic [31:0]          inst;
	} if_id_t;

	typedef struct packed {
		logic [`CPU_XLEN-1:0] pc;
		logic [`CPU_XLEN-1:0] rs1_val;
		logic [`CPU_XLEN-1:0] rs2_val;
		logic [`CPU_XLEN-1:0] imm;
		logic [4:0]           rs1;
		logic [4:0]           rs2;
		logic [4:0]           rd;
		ctrl_t                ctrl;
	} id_ex_t;

	typedef struct packed {
		logic [`CPU_XLEN-1:0] result;     // alu result, link or address
		logic [`CPU_XLEN-1:0] store_data;
		logic [4:0]           rd;
		logic                 reg_write;
		logic                 is_load;
		logic                 is_store;
	} ex_mem_t;

	typedef struct packed {
		logic [`CPU_XLEN-1:0] value;
		logic [4:0]           rd;
		logic                 reg_write;
	} mem_wb_t;

endpackage

//--- cpu_stimulus.txt
# columns: tag address value, i program word, d initial data word
# s expected store in program order, address then data
i 00000000 10000093 # addi x1, x0, 0x100
i 00000004 FFB00113 # addi x2, x0, -5
i 00000008 00300193 # addi x3, x0, 3
i 0000000C 00312233 # slt x4, x2, x3
i 00000010 0040A023 # sw x4, 0(x1)
i 00000014 003192B3 # sll x5, x3, x3
i 00000018 00415313 # srli x6, x2, 4
i 0000001C 0062C3B3 # xor x7, x5, x6
i 00000020 0070A223 # sw x7, 4(x1)
i 00000024 F800A403 # lw x8, -128(x1)
i 00000028 003404B3 # add x9, x8, x3 load-use
i 0000002C 0090A423 # sw x9, 8(x1)
i 00000030 ABCDE537 # lui x10, 0xabcde
i 00000034 00218463 # beq x3, x2, +8 not taken
i 00000038 00A0A623 # sw x10, 12(x1)
i 0000003C 00219663 # bne x3, x2, +12 taken
i 00000040 0020A823 # sw x2, 16(x1) flushed
i 00000044 0020A823 # sw x2, 16(x1) flushed
i 00000048 06300013 # addi x0, x0, 99
i 0000004C 0000A823 # sw x0, 16(x1)
i 00000050 00C005EF # jal x11, +12
i 00000054 0020AA23 # sw x2, 20(x1) flushed
i 00000058 0020AA23 # sw x2, 20(x1) flushed
i 0000005C 00B0AA23 # sw x11, 20(x1)
i 00000060 40218633 # sub x12, x3, x2
i 00000064 006176B3 # and x13, x2, x6
i 00000068 00A6E733 # or x14, x13, x10
i 0000006C 00E0AC23 # sw x14, 24(x1)
i 00000070 7FF64793 # xori x15, x12, 0x7ff
i 00000074 01479813 # slli x16, x15, 20
i 00000078 0100AE23 # sw x16, 28(x1)
i 0000007C 00C61463 # bne x12, x12, +8 not taken
i 00000080 02C0A023 # sw x12, 32(x1)
i 00000084 00C60463 # beq x12, x12, +8 taken
i 00000088 0220A223 # sw x2, 36(x1) flushed
i 0000008C 0000006F # jal x0, 0
d 00000080 12345678
s 00000100 00000001 # -5 < 3 signed
s 00000104 0FFFFFE7 # 0x18 ^ 0x0fffffff
s 00000108 1234567B # loaded word plus 3
s 0000010C ABCDE000
s 00000110 00000000 # x0 unchanged
s 00000114 00000054 # link of jal at 0x50
s 00000118 AFFFFFFB
s 0000011C 7F700000
s 00000120 00000008

//--- cpu_tb.sv
`include "cpu_macros.svh"

module cpu_tb;
	logic clock_i;
	logic rst_i;
	logic [31:0] inst_i;
	logic [`CPU_XLEN-1:0] load_data_i;
	logic [`CPU_XLEN-1:0] pc_o;
	logic [`CPU_XLEN-1:0] address_o;
	logic [`CPU_XLEN-1:0] store_data_o;
	logic mem_load_o;
	logic mem_store_o;

	logic [31:0] imem [64];
	logic [31:0] dmem [128];
	logic [31:0] exp_addr [$];
	logic [31:0] exp_data [$];
	int exp_idx;
	int stores;
	int errors;
	int cycles;

	cpu cpu_i (.*);

	always #20 clock_i = ~clock_i;

	task automatic load_stimulus();
		int fd;
		int n;
		logic [7:0] tag;
		logic [8*120-1:0] rest;
		logic [31:0] a;
		logic [31:0] v;
		fd = $fopen("cpu_stimulus.txt", "r");
		if (fd == 0) begin
			$display("could not open cpu_stimulus.txt");
			errors++;
			return;
		end
		while ($fscanf(fd, "%s", tag) == 1) begin
			if (tag == "#") begin
				n = $fgets(rest, fd); // comment up to end of line
			end else begin
				n = $fscanf(fd, "%h %h", a, v);
				case (tag)
					"i": imem[a[7:2]] = v;
					"d": dmem[a[8:2]] = v;
					"s": begin
						exp_addr.push_back(a);
						exp_data.push_back(v);
					end
					default: begin
						$display("unknown line tag in cpu_stimulus.txt");
						errors++;
					end
				endcase
			end
		end
		$fclose(fd);
	endtask

	task automatic check_store();
		stores++;
		assert (exp_idx < exp_addr.size()) else begin
			$display("unexpected store of %h to address %h at time %0t after the last one",
				store_data_o, address_o, $time);
			errors++;
		end
		if (exp_idx < exp_addr.size()) begin
			assert (address_o == exp_addr[exp_idx] && store_data_o == exp_data[exp_idx])
			else begin
				$display("MISMATCH at time %0t: store %0d wrote %h to %h, expected %h to %h",
					$time, exp_idx, store_data_o, address_o,
					exp_data[exp_idx], exp_addr[exp_idx]);
				errors++;
			end
			exp_idx++;
		end
		dmem[address_o[8:2]] = store_data_o;
	endtask

	// memories answer on the falling edge once outputs have settled
	always @(negedge clock_i) begin
		if (mem_store_o)
			check_store();
		inst_i <= imem[pc_o[7:2]];
		load_data_i <= mem_load_o ? dmem[address_o[8:2]] : 32'hDEAD_BEEF; // no data without a load
	end

	initial begin
		clock_i = 1'b0;
		rst_i = 1'b1;
		inst_i = '0;
		load_data_i = '0;
		exp_idx = 0;
		stores = 0;
		errors = 0;
		for (int k = 0; k < 64; k++)
			imem[k] = '0; // illegal word decoding to a bubble
		for (int k = 0; k < 128; k++)
			dmem[k] = (32'(k) << 2) ^ 32'hC3A5_5A3C;
		load_stimulus();

		for (cycles = 0; cycles < 10; cycles++)
			@(negedge clock_i);
		assert (pc_o == `CPU_RESET_PC) else begin
			$display("MISMATCH at time %0t: pc_o is %h at reset release, expected %h",
				$time, pc_o, `CPU_RESET_PC);
			errors++;
		end
		rst_i = 1'b0;

		for (cycles = 0; cycles < 2000 && exp_idx < exp_addr.size(); cycles++)
			@(negedge clock_i);
		assert (exp_idx >= exp_addr.size()) else begin
			$display("timed out after %0d cycles, %0d expected stores never appeared",
				cycles, exp_addr.size() - exp_idx);
			errors++;
		end

		// core spins in its closing loop where stray stores still get caught
		for (cycles = 0; cycles < 50; cycles++)
			@(negedge clock_i);

		$display("stores seen %0d, expected %0d, errors %0d", stores, exp_addr.size(), errors);
		if (errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

//--- decoder.sv
`include "cpu_macros.svh"

module decoder import cpu_pkg::*; (
	input  logic [31:0]          inst_i,
	output ctrl_t                ctrl_o,
	output logic [4:0]           rs1_o,
	output logic [4:0]           rs2_o,
	output logic [4:0]           rd_o,
	output logic [`CPU_XLEN-1:0] imm_o
);
	opcode_e opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic [`CPU_XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;
	alu_op_e arith_op;
	logic arith_bad;
	logic known;
	ctrl_t ctrl;

	assign opcode = opcode_e'(inst_i[6:0]);
	assign funct3 = inst_i[14:12];
	assign funct7 = inst_i[31:25];
	assign rs1_o = inst_i[19:15];
	assign rs2_o = inst_i[24:20];
	assign rd_o = inst_i[11:7];

	assign imm_i = {{(`CPU_XLEN-12){inst_i[31]}}, inst_i[31:20]};
	assign imm_s = {{(`CPU_XLEN-12){inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
	assign imm_b = {{(`CPU_XLEN-12){inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
	assign imm_u = {inst_i[31:12], 12'b0};
	assign imm_j = {{(`CPU_XLEN-20){inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

	// shared funct3 map for op and op_imm
	always_comb begin
		case (funct3)
			3'b000: arith_op = (opcode == opc_op && funct7[5]) ? alu_sub : alu_add;
			3'b001: arith_op = alu_sll;
			3'b010: arith_op = alu_slt;
			3'b100: arith_op = alu_xor;
			3'b101: arith_op = alu_srl;
			3'b110: arith_op = alu_or;
			3'b111: arith_op = alu_and;
			default: arith_op = alu_add; // sltu, not supported
		endcase
	end

	// sra, srai, sltu and the M extension fall out here
	assign arith_bad = (funct3 == 3'b011) ||
		(opcode == opc_op ?
			!(funct7 == 7'b0 || (funct7 == 7'b0100000 && funct3 == 3'b000)) :
			((funct3 == 3'b001 || funct3 == 3'b101) && funct7 != 7'b0));

	always_comb begin
		ctrl = '0;
		imm_o = '0;
		known = 1'b1;
		case (opcode)
			opc_op: begin
				ctrl.alu_op = arith_op;
				ctrl.reg_write = 1'b1;
				known = !arith_bad;
			end
			opc_op_imm: begin
				ctrl.alu_op = arith_op;
				ctrl.use_imm = 1'b1;
				ctrl.reg_write = 1'b1;
				imm_o = imm_i;
				known = !arith_bad;
			end
			opc_lui: begin
				ctrl.alu_op = alu_pass_b;
				ctrl.use_imm = 1'b1;
				ctrl.reg_write = 1'b1;
				imm_o = imm_u;
			end
			opc_load: begin
				ctrl.use_imm = 1'b1;
				ctrl.reg_write = 1'b1;
				ctrl.is_load = 1'b1;
				imm_o = imm_i;
				known = (funct3 == 3'b010); // lw only
			end
			opc_store: begin
				ctrl.use_imm = 1'b1;
				ctrl.is_store = 1'b1;
				imm_o = imm_s;
				known = (funct3 == 3'b010);
			end
			opc_branch: begin
				ctrl.alu_op = alu_sub; // zero flag does the compare
				ctrl.is_branch = 1'b1;
				ctrl.branch_ne = funct3[0];
				imm_o = imm_b;
				known = (funct3[2:1] == 2'b00);
			end
			opc_jal: begin
				ctrl.reg_write = 1'b1;
				ctrl.is_jump = 1'b1;
				imm_o = imm_j;
			end
			default: known = 1'b0;
		endcase
	end

	assign ctrl_o = known ? ctrl : '0;

endmodule

//--- gpr.sv
`include "cpu_macros.svh"

module gpr (
	input  logic                 clock_i,
	input  logic                 rst_i,
	input  logic                 we_i,
	input  logic [4:0]           waddr_i,
	input  logic [`CPU_XLEN-1:0] wdata_i,
	input  logic [4:0]           raddr1_i,
	input  logic [4:0]           raddr2_i,
	output logic [`CPU_XLEN-1:0] rdata1_o,
	output logic [`CPU_XLEN-1:0] rdata2_o
);
	logic [`CPU_XLEN-1:0] regs [`CPU_NREG];
	logic wr_en;

	assign wr_en = we_i && (waddr_i != 5'd0); // x0 stays zero

	always_ff @(posedge clock_i) begin
		if (rst_i) begin
			for (int i = 0; i < `CPU_NREG; i++)
				regs[i] <= '0;
		end else if (wr_en) begin
			regs[waddr_i] <= wdata_i;
		end
	end

	// write-back lands in decode the same cycle
	assign rdata1_o = (wr_en && waddr_i == raddr1_i) ? wdata_i : regs[raddr1_i];
	assign rdata2_o = (wr_en && waddr_i == raddr2_i) ? wdata_i : regs[raddr2_i];

endmodule

//--- hazard.sv
module hazard (
	input  logic [4:0] rs1_i,
	input  logic [4:0] rs2_i,
	input  logic [4:0] ex_rd_i,
	input  logic       ex_is_load_i,
	input  logic       redirect_i,
	output logic       stall_o,
	output logic       flush_o
);
	logic rd_hit;
	logic load_use;

	// sources of the decode instruction against the load in execute
	assign rd_hit = (ex_rd_i != 5'd0) && (ex_rd_i == rs1_i || ex_rd_i == rs2_i);
	assign load_use = ex_is_load_i && rd_hit;

	// flush wins over stall
	assign flush_o = redirect_i;
	assign stall_o = load_use && !redirect_i;

endmodule
